// File: pcw_cfg.svh
// Port numbers, register reset values and widths for the PCW I/O block
// Shared by the package and the register stages

`ifndef PCW_CFG_SVH
`define PCW_CFG_SVH

// System I/O ports, low address byte
`define PCW_PORT_BANK0  8'hF0
`define PCW_PORT_BANK1  8'hF1
`define PCW_PORT_BANK2  8'hF2
`define PCW_PORT_BANK3  8'hF3
`define PCW_PORT_LOCK   8'hF4   // CPC read lock, status read with timer clear
`define PCW_PORT_ROLLER 8'hF5
`define PCW_PORT_SCROLL 8'hF6
`define PCW_PORT_VIDEO  8'hF7
`define PCW_PORT_CTRL   8'hF8   // System control write, status read

// Bank n comes out of reset as base plus n
`define PCW_BANK_RST_BASE 8'h80
`define PCW_LOCK_RST      8'hF1
`define PCW_VIDEO_RST     8'h80   // Inverse set, video blanked

// Widths
`define PCW_RAM_ADDR_W 21
`define PCW_MISS_W     4

`endif

// File: pcw_pkg.sv
// Types shared by the PCW I/O block
// Memory size and system command encodings, address and byte types

`include "pcw_cfg.svh"

package pcw_pkg;

    typedef logic [7:0]                   pcw_byte_t;
    typedef logic [15:0]                  cpu_addr_t;
    typedef logic [`PCW_RAM_ADDR_W-1:0]   ram_addr_t;
    typedef logic [`PCW_MISS_W-1:0]       miss_cnt_t;

    // Fitted RAM, selects the bank mask in PCW mode
    typedef enum logic [1:0] {
        MEM_256K = 2'd0,
        MEM_512K = 2'd1,
        MEM_1M   = 2'd2,
        MEM_2M   = 2'd3
    } mem_size_t;

    // Low nibble of a write to the system control port
    typedef enum logic [3:0] {
        CMD_BOOT_END  = 4'd0,
        CMD_DISK_NMI  = 4'd2,
        CMD_DISK_INT  = 4'd3,
        CMD_DISK_OFF  = 4'd4,
        CMD_TC_SET    = 4'd5,
        CMD_TC_CLR    = 4'd6,
        CMD_MOTOR_ON  = 4'd9,
        CMD_MOTOR_OFF = 4'd10,
        CMD_SPK_ON    = 4'd11,
        CMD_SPK_OFF   = 4'd12
    } sys_cmd_t;

endpackage

// File: pcw_io_decode.sv
// I/O port decode for ports F0 to F8
// Write strobes per register and read selects for the status byte

`include "pcw_cfg.svh"

module pcw_io_decode (
    input  pcw_pkg::cpu_addr_t cpu_addr,
    input  logic               io_rd,
    input  logic               io_wr,
    output logic [3:0]         bank_wr,
    output logic               lock_wr,
    output logic               roller_wr,
    output logic               scroll_wr,
    output logic               video_wr,
    output logic               ctrl_wr,
    output logic               status_rd,
    output logic               timer_clr_rd
);
    import pcw_pkg::*;

    pcw_byte_t port_lo;   // Only the low byte selects a system port

    assign port_lo = cpu_addr[7:0];

    // Paging registers, one-hot by quarter
    assign bank_wr[0] = io_wr && (port_lo == `PCW_PORT_BANK0);
    assign bank_wr[1] = io_wr && (port_lo == `PCW_PORT_BANK1);
    assign bank_wr[2] = io_wr && (port_lo == `PCW_PORT_BANK2);
    assign bank_wr[3] = io_wr && (port_lo == `PCW_PORT_BANK3);

    assign lock_wr   = io_wr && (port_lo == `PCW_PORT_LOCK);
    assign roller_wr = io_wr && (port_lo == `PCW_PORT_ROLLER);
    assign scroll_wr = io_wr && (port_lo == `PCW_PORT_SCROLL);
    assign video_wr  = io_wr && (port_lo == `PCW_PORT_VIDEO);
    assign ctrl_wr   = io_wr && (port_lo == `PCW_PORT_CTRL);

    // F8 and F4 both return the status byte
    assign status_rd = io_rd &&
                       ((port_lo == `PCW_PORT_CTRL) || (port_lo == `PCW_PORT_LOCK));

    // Reading F4 also arms the timer clear
    assign timer_clr_rd = io_rd && (port_lo == `PCW_PORT_LOCK);

endmodule

// File: pcw_port_regs.sv
// Bank, CPC lock and video registers
// System control command decoder for port F8

`include "pcw_cfg.svh"

module pcw_port_regs (
    input  logic               clk_sys,
    input  logic               reset,
    input  pcw_pkg::pcw_byte_t cpu_dout,
    input  logic [3:0]         bank_wr,
    input  logic               lock_wr,
    input  logic               roller_wr,
    input  logic               scroll_wr,
    input  logic               video_wr,
    input  logic               ctrl_wr,
    output pcw_pkg::pcw_byte_t bank0,
    output pcw_pkg::pcw_byte_t bank1,
    output pcw_pkg::pcw_byte_t bank2,
    output pcw_pkg::pcw_byte_t bank3,
    output pcw_pkg::pcw_byte_t lock,
    output pcw_pkg::pcw_byte_t roller_ptr,
    output pcw_pkg::pcw_byte_t yscroll,
    output logic               inverse,
    output logic               vid_enable,
    output logic               disk_to_nmi,
    output logic               disk_to_int,
    output logic               disk_int_sel,
    output logic               fdc_tc,
    output logic               motor,
    output logic               speaker_enable
);
    import pcw_pkg::*;

    pcw_byte_t bank_q [4];
    pcw_byte_t video_q;
    sys_cmd_t  cmd;

    assign cmd = sys_cmd_t'(cpu_dout[3:0]);   // Upper nibble ignored

    // Paging and video registers
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank_q[i] <= pcw_byte_t'(`PCW_BANK_RST_BASE + i);
            end
            lock       <= `PCW_LOCK_RST;
            roller_ptr <= 8'h00;
            yscroll    <= 8'h00;
            video_q    <= `PCW_VIDEO_RST;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (bank_wr[i]) bank_q[i] <= cpu_dout;
            end
            if (lock_wr)   lock       <= cpu_dout;
            if (roller_wr) roller_ptr <= cpu_dout;
            if (scroll_wr) yscroll    <= cpu_dout;
            if (video_wr)  video_q    <= cpu_dout;
        end
    end

    assign bank0 = bank_q[0];
    assign bank1 = bank_q[1];
    assign bank2 = bank_q[2];
    assign bank3 = bank_q[3];

    assign inverse    = video_q[7];
    assign vid_enable = video_q[6];

    // System control commands
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            disk_to_nmi    <= 1'b0;
            disk_to_int    <= 1'b0;
            disk_int_sel   <= 1'b0;
            fdc_tc         <= 1'b0;
            motor          <= 1'b0;
            speaker_enable <= 1'b0;
        end else begin
            disk_int_sel <= 1'b0;
            if (ctrl_wr) begin
                case (cmd)
                    CMD_DISK_NMI: begin
                        disk_to_nmi <= 1'b1;
                        disk_to_int <= 1'b0;
                    end
                    CMD_DISK_INT: begin
                        disk_to_int  <= 1'b1;
                        disk_to_nmi  <= 1'b0;
                        disk_int_sel <= 1'b1;   // Lets a pending NMI go
                    end
                    CMD_DISK_OFF: begin
                        disk_to_nmi <= 1'b0;
                        disk_to_int <= 1'b0;
                    end
                    CMD_TC_SET:    fdc_tc         <= 1'b1;
                    CMD_TC_CLR:    fdc_tc         <= 1'b0;
                    CMD_MOTOR_ON:  motor          <= 1'b1;
                    CMD_MOTOR_OFF: motor          <= 1'b0;
                    CMD_SPK_ON:    speaker_enable <= 1'b1;
                    CMD_SPK_OFF:   speaker_enable <= 1'b0;
                    default: ;   // Boot end and unused codes
                endcase
            end
        end
    end

endmodule

// File: pcw_page_map.sv
// CPU to RAM address translation
// PCW paged mode with size masking, CPC mode with the read lock

module pcw_page_map (
    input  pcw_pkg::cpu_addr_t cpu_addr,
    input  logic               mem_wr,
    input  pcw_pkg::mem_size_t memory_size,
    input  pcw_pkg::pcw_byte_t bank0,
    input  pcw_pkg::pcw_byte_t bank1,
    input  pcw_pkg::pcw_byte_t bank2,
    input  pcw_pkg::pcw_byte_t bank3,
    input  pcw_pkg::pcw_byte_t lock,
    output pcw_pkg::ram_addr_t ram_addr
);
    import pcw_pkg::*;

    logic [1:0]  quarter;
    logic [13:0] offset;
    pcw_byte_t   bank_sel;
    logic [6:0]  pcw_bank;   // 16K block number, up to 2M
    logic [2:0]  cpc_bank;
    logic        lock_bit;

    assign quarter = cpu_addr[15:14];
    assign offset  = cpu_addr[13:0];

    always_comb begin
        case (quarter)
            2'd0:    bank_sel = bank0;
            2'd1:    bank_sel = bank1;
            2'd2:    bank_sel = bank2;
            default: bank_sel = bank3;
        endcase
    end

    // Drop block bits beyond the fitted memory
    always_comb begin
        case (memory_size)
            MEM_256K: pcw_bank = {3'b000, bank_sel[3:0]};
            MEM_512K: pcw_bank = {2'b00, bank_sel[4:0]};
            MEM_1M:   pcw_bank = {1'b0, bank_sel[5:0]};
            default:  pcw_bank = bank_sel[6:0];
        endcase
    end

    // Lock bits 7..4 belong to quarters 3..0
    assign lock_bit = lock[{1'b1, quarter}];

    // Writes always use the low field, reads only when locked
    assign cpc_bank = (mem_wr || lock_bit) ? bank_sel[2:0] : bank_sel[6:4];

    always_comb begin
        if (bank_sel[7]) begin
            ram_addr = ram_addr_t'({pcw_bank, offset});
        end else begin
            ram_addr = ram_addr_t'({cpc_bank, offset});   // Zero extended
        end
    end

endmodule

// File: pcw_int_ctrl.sv
// Floppy latch, NMI flag, 300 Hz timer miss counter and interrupt lines
// Status byte read mux for ports F8 and F4

module pcw_int_ctrl (
    input  logic               clk_sys,
    input  logic               reset,
    input  logic               fdc_int,
    input  logic               vid_timer,
    input  logic               m1,
    input  logic               io_rd,
    input  logic               io_wr,
    input  logic               status_rd,
    input  logic               timer_clr_rd,
    input  logic               disk_to_nmi,
    input  logic               disk_to_int,
    input  logic               disk_int_sel,
    input  logic               ntsc,
    input  logic               vblank,
    output pcw_pkg::pcw_byte_t io_din,
    output logic               nmi_n,
    output logic               int_n
);
    import pcw_pkg::*;

    logic      fdc_last;
    logic      vid_last;
    logic      m1_last;
    logic      fdc_rise;
    logic      fdc_fall;
    logic      vid_rise;
    logic      m1_fall;
    logic      fdc_latch;
    logic      nmi_flag;
    logic      nmi_line;
    logic      timer_line;
    logic      int_line;
    logic      clr_pending;   // F4 read seen, waiting for next fetch
    miss_cnt_t miss_cnt;
    pcw_byte_t status_byte;

    assign fdc_rise = fdc_int & ~fdc_last;
    assign fdc_fall = ~fdc_int & fdc_last;
    assign vid_rise = vid_timer & ~vid_last;

    // Opcode fetch start, not during an I/O cycle
    assign m1_fall = m1_last & ~m1 & ~io_rd & ~io_wr;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            fdc_last    <= 1'b0;
            vid_last    <= 1'b0;
            m1_last     <= 1'b0;
            fdc_latch   <= 1'b0;
            nmi_flag    <= 1'b0;
            nmi_line    <= 1'b0;
            timer_line  <= 1'b0;
            int_line    <= 1'b0;
            clr_pending <= 1'b0;
            miss_cnt    <= '0;
        end else begin
            fdc_last <= fdc_int;
            vid_last <= vid_timer;
            m1_last  <= m1;
            nmi_line <= nmi_flag;   // NMI pin lags the flag by a cycle
            int_line <= 1'b0;

            // Floppy interrupt latch and NMI routing
            if (fdc_rise) begin
                fdc_latch <= 1'b1;
                if (disk_to_nmi) nmi_flag <= 1'b1;
            end else if (fdc_fall) begin
                fdc_latch <= 1'b0;
            end
            if (disk_int_sel) nmi_flag <= 1'b0;

            // 300 Hz tick, count missed ticks up to the top
            if (vid_rise) begin
                if (!(&miss_cnt)) miss_cnt <= miss_cnt + 1'b1;
                timer_line <= 1'b1;
                int_line   <= disk_to_int & fdc_latch;
            end

            if (timer_clr_rd) clr_pending <= 1'b1;

            // Deferred clear wins over a tick in the same cycle
            if (clr_pending && m1_fall) begin
                clr_pending <= 1'b0;
                miss_cnt    <= '0;
                timer_line  <= 1'b0;
            end
        end
    end

    assign nmi_n = ~nmi_line;
    assign int_n = nmi_line ? 1'b1 : ~(timer_line | int_line);   // NMI masks INT

    // 0, vblank, floppy latch, not ntsc, miss count
    assign status_byte = {1'b0, vblank, fdc_latch, ~ntsc, miss_cnt};
    assign io_din      = status_rd ? status_byte : 8'hFF;

endmodule

// File: pcw_io_core.sv
// System control I/O block of the PCW core
// Port decode, registers, paging and interrupt stages

module pcw_io_core (
    input  logic               clk_sys,
    input  logic               reset,
    input  pcw_pkg::cpu_addr_t cpu_addr,
    input  pcw_pkg::pcw_byte_t cpu_dout,
    input  logic               io_rd,
    input  logic               io_wr,
    input  logic               mem_wr,
    input  logic               m1,
    input  logic               fdc_int,
    input  logic               vid_timer,
    input  logic               ntsc,
    input  logic               vblank,
    input  pcw_pkg::mem_size_t memory_size,
    output pcw_pkg::ram_addr_t ram_addr,
    output pcw_pkg::pcw_byte_t io_din,
    output logic               nmi_n,
    output logic               int_n,
    output pcw_pkg::pcw_byte_t roller_ptr,
    output pcw_pkg::pcw_byte_t yscroll,
    output logic               inverse,
    output logic               vid_enable,
    output logic               fdc_tc,
    output logic               motor,
    output logic               speaker_enable
);
    import pcw_pkg::*;

    // Decode strobes
    logic [3:0] bank_wr;
    logic       lock_wr;
    logic       roller_wr;
    logic       scroll_wr;
    logic       video_wr;
    logic       ctrl_wr;
    logic       status_rd;
    logic       timer_clr_rd;

    // Register outputs to paging and interrupts
    pcw_byte_t  bank0;
    pcw_byte_t  bank1;
    pcw_byte_t  bank2;
    pcw_byte_t  bank3;
    pcw_byte_t  lock;
    logic       disk_to_nmi;
    logic       disk_to_int;
    logic       disk_int_sel;

    pcw_io_decode u_pcw_io_decode (
        .cpu_addr     (cpu_addr),
        .io_rd        (io_rd),
        .io_wr        (io_wr),
        .bank_wr      (bank_wr),
        .lock_wr      (lock_wr),
        .roller_wr    (roller_wr),
        .scroll_wr    (scroll_wr),
        .video_wr     (video_wr),
        .ctrl_wr      (ctrl_wr),
        .status_rd    (status_rd),
        .timer_clr_rd (timer_clr_rd)
    );

    pcw_port_regs u_pcw_port_regs (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .cpu_dout       (cpu_dout),
        .bank_wr        (bank_wr),
        .lock_wr        (lock_wr),
        .roller_wr      (roller_wr),
        .scroll_wr      (scroll_wr),
        .video_wr       (video_wr),
        .ctrl_wr        (ctrl_wr),
        .bank0          (bank0),
        .bank1          (bank1),
        .bank2          (bank2),
        .bank3          (bank3),
        .lock           (lock),
        .roller_ptr     (roller_ptr),
        .yscroll        (yscroll),
        .inverse        (inverse),
        .vid_enable     (vid_enable),
        .disk_to_nmi    (disk_to_nmi),
        .disk_to_int    (disk_to_int),
        .disk_int_sel   (disk_int_sel),
        .fdc_tc         (fdc_tc),
        .motor          (motor),
        .speaker_enable (speaker_enable)
    );

    pcw_page_map u_pcw_page_map (
        .cpu_addr    (cpu_addr),
        .mem_wr      (mem_wr),
        .memory_size (memory_size),
        .bank0       (bank0),
        .bank1       (bank1),
        .bank2       (bank2),
        .bank3       (bank3),
        .lock        (lock),
        .ram_addr    (ram_addr)
    );

    pcw_int_ctrl u_pcw_int_ctrl (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .fdc_int      (fdc_int),
        .vid_timer    (vid_timer),
        .m1           (m1),
        .io_rd        (io_rd),
        .io_wr        (io_wr),
        .status_rd    (status_rd),
        .timer_clr_rd (timer_clr_rd),
        .disk_to_nmi  (disk_to_nmi),
        .disk_to_int  (disk_to_int),
        .disk_int_sel (disk_int_sel),
        .ntsc         (ntsc),
        .vblank       (vblank),
        .io_din       (io_din),
        .nmi_n        (nmi_n),
        .int_n        (int_n)
    );

endmodule

// File: pcw_io_checker.sv
// Bound assertion checker for the PCW I/O block
// Reference model of registers, miss count, floppy latch and NMI

`include "pcw_cfg.svh"

module pcw_io_checker (
    input logic               clk_sys,
    input logic               reset,
    input pcw_pkg::cpu_addr_t cpu_addr,
    input pcw_pkg::pcw_byte_t cpu_dout,
    input logic               io_rd,
    input logic               io_wr,
    input logic               mem_wr,
    input logic               m1,
    input logic               fdc_int,
    input logic               vid_timer,
    input logic               ntsc,
    input logic               vblank,
    input pcw_pkg::mem_size_t memory_size,
    input pcw_pkg::ram_addr_t ram_addr,
    input pcw_pkg::pcw_byte_t io_din,
    input logic               nmi_n,
    input logic               int_n,
    input pcw_pkg::pcw_byte_t roller_ptr,
    input pcw_pkg::pcw_byte_t yscroll,
    input logic               inverse,
    input logic               vid_enable,
    input logic               fdc_tc,
    input logic               motor,
    input logic               speaker_enable
);
    timeunit 1ns;
    timeprecision 1ps;
    import pcw_pkg::*;

    int        err_count = 0;   // Read by the testbench
    pcw_byte_t bank_m [4];
    pcw_byte_t lock_m;
    pcw_byte_t roller_m;
    pcw_byte_t scroll_m;
    pcw_byte_t video_m;
    logic      tc_m;
    logic      motor_m;
    logic      spk_m;
    logic      to_nmi_m;
    logic      to_int_m;
    logic      int_sel_m;
    logic      fdc_last_m;
    logic      vid_last_m;
    logic      m1_last_m;
    logic      latch_m;
    logic      pend_m;       // F4 read seen
    logic      nmi_flag_m;
    logic      nmi_line_m;
    logic      int_m;        // Floppy INT pulse at a timer edge
    miss_cnt_t miss_m;
    pcw_byte_t port;
    ram_addr_t exp_addr;
    pcw_byte_t exp_status;

    assign port = cpu_addr[7:0];

    // Expected RAM address from the paging rules
    function automatic ram_addr_t expect_addr(input cpu_addr_t a, input logic wr,
                                              input mem_size_t sz);
        pcw_byte_t  b;
        int         keep;
        logic [1:0] q;
        q    = a[15:14];
        b    = bank_m[q];
        keep = 4 + int'(sz);   // 4 to 7 block bits
        if (b[7]) begin
            return ram_addr_t'({b[6:0] & 7'((1 << keep) - 1), a[13:0]});
        end
        if (wr || lock_m[4 + q]) begin
            return ram_addr_t'({b[2:0], a[13:0]});
        end
        return ram_addr_t'({b[6:4], a[13:0]});
    endfunction

    always_comb exp_addr = expect_addr(cpu_addr, mem_wr, memory_size);

    always_comb begin
        exp_status = 8'hFF;
        if (io_rd && (port == `PCW_PORT_CTRL || port == `PCW_PORT_LOCK)) begin
            exp_status = {1'b0, vblank, latch_m, ~ntsc, miss_m};
        end
    end

    // Register model
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank_m[i] <= pcw_byte_t'(`PCW_BANK_RST_BASE + i);
            end
            lock_m    <= `PCW_LOCK_RST;
            roller_m  <= '0;
            scroll_m  <= '0;
            video_m   <= `PCW_VIDEO_RST;
            tc_m      <= 1'b0;
            motor_m   <= 1'b0;
            spk_m     <= 1'b0;
            to_nmi_m  <= 1'b0;
            to_int_m  <= 1'b0;
            int_sel_m <= 1'b0;
        end else begin
            int_sel_m <= 1'b0;
            if (io_wr) begin
                case (port)
                    `PCW_PORT_BANK0:  bank_m[0] <= cpu_dout;
                    `PCW_PORT_BANK1:  bank_m[1] <= cpu_dout;
                    `PCW_PORT_BANK2:  bank_m[2] <= cpu_dout;
                    `PCW_PORT_BANK3:  bank_m[3] <= cpu_dout;
                    `PCW_PORT_LOCK:   lock_m    <= cpu_dout;
                    `PCW_PORT_ROLLER: roller_m  <= cpu_dout;
                    `PCW_PORT_SCROLL: scroll_m  <= cpu_dout;
                    `PCW_PORT_VIDEO:  video_m   <= cpu_dout;
                    default: ;
                endcase
            end
            if (io_wr && port == `PCW_PORT_CTRL) begin
                case (cpu_dout[3:0])
                    CMD_DISK_NMI: begin
                        to_nmi_m <= 1'b1;
                        to_int_m <= 1'b0;
                    end
                    CMD_DISK_INT: begin
                        to_nmi_m  <= 1'b0;
                        to_int_m  <= 1'b1;
                        int_sel_m <= 1'b1;
                    end
                    CMD_DISK_OFF: begin
                        to_nmi_m <= 1'b0;
                        to_int_m <= 1'b0;
                    end
                    CMD_TC_SET:    tc_m     <= 1'b1;
                    CMD_TC_CLR:    tc_m     <= 1'b0;
                    CMD_MOTOR_ON:  motor_m  <= 1'b1;
                    CMD_MOTOR_OFF: motor_m  <= 1'b0;
                    CMD_SPK_ON:    spk_m    <= 1'b1;
                    CMD_SPK_OFF:   spk_m    <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // Interrupt model
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            fdc_last_m <= 1'b0;
            vid_last_m <= 1'b0;
            m1_last_m  <= 1'b0;
            latch_m    <= 1'b0;
            pend_m     <= 1'b0;
            nmi_flag_m <= 1'b0;
            nmi_line_m <= 1'b0;
            int_m      <= 1'b0;
            miss_m     <= '0;
        end else begin
            fdc_last_m <= fdc_int;
            vid_last_m <= vid_timer;
            m1_last_m  <= m1;
            nmi_line_m <= nmi_flag_m;
            int_m      <= 1'b0;
            if (fdc_int && !fdc_last_m) begin
                latch_m <= 1'b1;
                if (to_nmi_m) nmi_flag_m <= 1'b1;
            end else if (!fdc_int && fdc_last_m) begin
                latch_m <= 1'b0;
            end
            if (int_sel_m) nmi_flag_m <= 1'b0;
            if (vid_timer && !vid_last_m) begin
                int_m <= to_int_m && latch_m;
                if (miss_m != '1) miss_m <= miss_m + 1'b1;
            end
            if (io_rd && port == `PCW_PORT_LOCK) pend_m <= 1'b1;
            if (pend_m && m1_last_m && !m1 && !io_rd && !io_wr) begin
                pend_m <= 1'b0;
                miss_m <= '0;   // Clear beats a tick
            end
        end
    end

    a_reset_state: assert property (@(posedge clk_sys) disable iff (reset)
        $past(reset) |-> nmi_n && int_n && !fdc_tc && !motor && !speaker_enable)
        else begin
            err_count++;
            $error("Fail %0t: outputs not inactive after reset", $time);
        end

    a_ram_addr: assert property (@(posedge clk_sys) disable iff (reset)
        ram_addr == exp_addr)
        else begin
            err_count++;
            $error("Fail %0t: ram_addr %h, expected %h", $time, ram_addr, exp_addr);
        end

    a_ctrl: assert property (@(posedge clk_sys) disable iff (reset)
        {fdc_tc, motor, speaker_enable} == {tc_m, motor_m, spk_m})
        else begin
            err_count++;
            $error("Fail %0t: tc, motor or speaker wrong", $time);
        end

    a_video: assert property (@(posedge clk_sys) disable iff (reset)
        {roller_ptr, yscroll, inverse, vid_enable} ==
        {roller_m, scroll_m, video_m[7], video_m[6]})
        else begin
            err_count++;
            $error("Fail %0t: video registers wrong", $time);
        end

    a_status: assert property (@(posedge clk_sys) disable iff (reset)
        io_din == exp_status)
        else begin
            err_count++;
            $error("Fail %0t: io_din %h, expected %h", $time, io_din, exp_status);
        end

    a_nmi: assert property (@(posedge clk_sys) disable iff (reset)
        nmi_n == !nmi_line_m)
        else begin
            err_count++;
            $error("Fail %0t: nmi_n %b, expected %b", $time, nmi_n, !nmi_line_m);
        end

    // Timer line stays up exactly while misses are counted
    a_int: assert property (@(posedge clk_sys) disable iff (reset)
        int_n == (nmi_line_m || (miss_m == '0 && !int_m)))
        else begin
            err_count++;
            $error("Fail %0t: int_n %b with miss count %0d", $time, int_n, miss_m);
        end

endmodule

bind pcw_io_core pcw_io_checker u_pcw_io_checker (.*);

// File: tb_pcw_io_core.sv
// Testbench for the PCW I/O block
// Clock, reset, directed and random stimulus, watchdog and final report

`include "pcw_cfg.svh"

module tb_pcw_io_core;
    timeunit 1ns;
    timeprecision 1ps;
    import pcw_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int SEED       = 78410;
    localparam int N_ADDR     = 12;   // Read/write address pairs per sweep
    localparam int WAIT_LIMIT = 8;
    localparam int TEST_CYCLES = 3 + 2 * N_ADDR + 4 * (4 + 2 * N_ADDR)
                               + 2 * (5 + 2 * N_ADDR) + 38 + 44 + 11 + 2 * WAIT_LIMIT;
    localparam int MARGIN_CYCLES = 50;

    logic      clk_sys;
    logic      reset;
    cpu_addr_t cpu_addr;
    pcw_byte_t cpu_dout;
    logic      io_rd;
    logic      io_wr;
    logic      mem_wr;
    logic      m1;
    logic      fdc_int;
    logic      vid_timer;
    logic      ntsc;
    logic      vblank;
    mem_size_t memory_size;
    ram_addr_t ram_addr;
    pcw_byte_t io_din;
    pcw_byte_t roller_ptr;
    pcw_byte_t yscroll;
    logic      nmi_n;
    logic      int_n;
    logic      inverse;
    logic      vid_enable;
    logic      fdc_tc;
    logic      motor;
    logic      speaker_enable;
    int        tb_errors = 0;

    pcw_io_core u_pcw_io_core (.*);

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    task automatic next_cycle();
        @(posedge clk_sys);
        #DRIVE_DLY;
    endtask

    task automatic io_write(input pcw_byte_t port, input pcw_byte_t data);
        cpu_addr = {8'h00, port};
        cpu_dout = data;
        io_wr    = 1'b1;
        next_cycle();
        io_wr    = 1'b0;
    endtask

    task automatic io_read(input pcw_byte_t port);
        cpu_addr = {8'h00, port};
        io_rd    = 1'b1;
        next_cycle();
        io_rd    = 1'b0;
    endtask

    // Each random address once as a read, then as a write
    task automatic sweep_addresses(input int pairs);
        repeat (pairs) begin
            cpu_addr        = cpu_addr_t'($urandom);
            {ntsc, vblank}  = 2'($urandom);
            mem_wr          = 1'b0;
            next_cycle();
            mem_wr          = 1'b1;
            next_cycle();
        end
        mem_wr = 1'b0;
    endtask

    task automatic timer_tick();
        vid_timer = 1'b1;
        next_cycle();
        vid_timer = 1'b0;
        next_cycle();
    endtask

    task automatic opcode_fetch();
        m1 = 1'b1;
        next_cycle();
        m1 = 1'b0;
        next_cycle();
    endtask

    task automatic wait_nmi(input logic level, input string what);
        int n;
        n = 0;
        while (nmi_n !== level && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (nmi_n !== level) begin
            tb_errors++;
            $display("Fail %0t: %s", $time, what);
        end
    endtask

    initial begin : watchdog
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        int chk_errors;
        void'($urandom(SEED));
        reset = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        {io_rd, io_wr, mem_wr, m1} = 4'b0000;
        {fdc_int, vid_timer, ntsc, vblank} = 4'b0000;
        memory_size = MEM_256K;
        repeat (3) @(posedge clk_sys);
        #DRIVE_DLY;
        reset = 1'b0;

        sweep_addresses(N_ADDR);   // Reset banks, quarter n maps to block n

        // PCW paging across all memory sizes
        for (int s = 0; s < 4; s++) begin
            memory_size = mem_size_t'(s);
            for (int q = 0; q < 4; q++) begin
                io_write(pcw_byte_t'(`PCW_PORT_BANK0 + q), {1'b1, 7'($urandom)});
            end
            sweep_addresses(N_ADDR);
        end

        // CPC paging with two lock patterns
        repeat (2) begin
            io_write(`PCW_PORT_LOCK, pcw_byte_t'($urandom));
            for (int q = 0; q < 4; q++) begin
                io_write(pcw_byte_t'(`PCW_PORT_BANK0 + q), {1'b0, 7'($urandom)});
            end
            sweep_addresses(N_ADDR);
        end

        // Every command code, junk in the upper nibble
        for (int c = 0; c < 16; c++) begin
            io_write(`PCW_PORT_CTRL, {4'($urandom), 4'(c)});
            next_cycle();
        end
        repeat (2) begin
            io_write(`PCW_PORT_ROLLER, pcw_byte_t'($urandom));
            io_write(`PCW_PORT_SCROLL, pcw_byte_t'($urandom));
            io_write(`PCW_PORT_VIDEO, pcw_byte_t'($urandom));
        end

        // Miss counter up to saturation, then deferred clear
        repeat (20) timer_tick();
        io_read(`PCW_PORT_CTRL);
        io_read(`PCW_PORT_LOCK);
        opcode_fetch();

        // Floppy interrupt routed to NMI, then moved to INT
        io_write(`PCW_PORT_CTRL, pcw_byte_t'(CMD_DISK_NMI));
        fdc_int = 1'b1;
        wait_nmi(1'b0, "nmi_n did not go low after the floppy interrupt");
        timer_tick();   // NMI holds INT off
        io_read(`PCW_PORT_CTRL);
        io_write(`PCW_PORT_CTRL, pcw_byte_t'(CMD_DISK_INT));
        wait_nmi(1'b1, "nmi_n was not released by the disk-to-INT command");
        io_read(`PCW_PORT_LOCK);
        m1 = 1'b1;
        next_cycle();
        m1 = 1'b0;
        timer_tick();   // Fetch end and tick share an edge
        fdc_int = 1'b0;
        repeat (2) next_cycle();

        chk_errors = u_pcw_io_core.u_pcw_io_checker.err_count;
        $display("Errors: %0d from assertions, %0d from testbench", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
pcw_pkg.sv
pcw_io_decode.sv
pcw_port_regs.sv
pcw_page_map.sv
pcw_int_ctrl.sv
pcw_io_core.sv
pcw_io_checker.sv
tb_pcw_io_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pcw_io_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
